/* include/ddr4_cfg.svh */
`ifndef DDR4_CFG_SVH
`define DDR4_CFG_SVH

// Latencies in controller clocks
`define DDR4_CAS_LATENCY        22
`define DDR4_ACTIVATION_LATENCY 8
`define DDR4_PRECHARGE_LATENCY  5

// Address field widths
`define DDR4_ROW_BITS   8
`define DDR4_COL_BITS   4
`define DDR4_PADDR_BITS 19

`define DDR4_DATA_BITS 64

// Four bank groups of four banks
`define DDR4_NUM_BANKS 16

`endif

/* hw/ddr4_pkg.sv */
`include "ddr4_cfg.svh"

package ddr4_pkg;

  // Request address, write flag on top
  typedef logic [`DDR4_PADDR_BITS-1:0] paddr_t;
  typedef logic [`DDR4_DATA_BITS-1:0] data_t;
  typedef logic [`DDR4_DATA_BITS-1:0] mask_t;  // Set bit keeps stored bit
  typedef logic [`DDR4_ROW_BITS-1:0] row_t;
  typedef logic [`DDR4_COL_BITS-1:0] col_t;
  typedef logic [$clog2(`DDR4_NUM_BANKS)-1:0] bank_idx_t;  // {bg, ba}

  typedef struct packed {
    paddr_t addr;
    data_t  wdata;
    mask_t  wmask;
  } mem_req_t;

  // DIMM command pins
  typedef struct packed {
    logic        cs_n;
    logic        act;
    logic [16:0] addr;  // Row on ACTIVATE, RAS_n/CAS_n/WE_n in 16:14 otherwise
    logic [1:0]  bg;
    logic [1:0]  ba;
    mask_t       dqm;
  } dram_cmd_t;

  typedef enum logic [2:0] {
    OP_NOP,
    OP_ACTIVATE,
    OP_READ,
    OP_WRITE,
    OP_PRECHARGE
  } dram_op_e;

  typedef struct packed {
    logic  act;
    logic  rd;
    logic  wr;
    logic  pre;
    row_t  row;
    col_t  col;
    data_t wdata;
    mask_t dqm;
  } bank_ctl_t;

  // Read issued to one bank
  typedef struct packed {
    logic      valid;
    bank_idx_t bank;
  } rd_strobe_t;

endpackage

/* hw/ddr4_sdram_controller.sv */
`timescale 1ns/100ps
`include "ddr4_cfg.svh"

module ddr4_sdram_controller import ddr4_pkg::*; (
  input  logic      clk_in,
  input  logic      rst_n,
  input  logic      valid,
  input  mem_req_t  req,
  output logic      busy,
  output dram_cmd_t cmd,
  output data_t     dq_wr
);

  localparam int CNT_W = $clog2(`DDR4_CAS_LATENCY);

  // Address field positions below the write flag
  localparam int ROW_LSB = `DDR4_COL_BITS;
  localparam int BANK_LSB = ROW_LSB + `DDR4_ROW_BITS;

  typedef enum logic [2:0] {
    IDLE,
    ACTIVATE,
    WAIT_RCD,
    COLUMN,
    WAIT_CL,
    PRECHARGE,
    WAIT_RP
  } state_e;

  state_e           state;
  logic [CNT_W-1:0] cnt;
  mem_req_t         req_q;
  logic             is_write;
  bank_idx_t        bank;
  row_t             row;
  col_t             col;

  assign is_write = req_q.addr[`DDR4_PADDR_BITS-1];
  assign bank = req_q.addr[BANK_LSB +: $bits(bank_idx_t)];
  assign row = req_q.addr[ROW_LSB +: `DDR4_ROW_BITS];
  assign col = req_q.addr[`DDR4_COL_BITS-1:0];

  assign busy = (state != IDLE);

  // Each wait state lasts latency minus one cycles
  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        IDLE: if (valid) state <= ACTIVATE;
        ACTIVATE: begin
          state <= WAIT_RCD;
          cnt   <= CNT_W'(`DDR4_ACTIVATION_LATENCY - 2);
        end
        WAIT_RCD: if (cnt == '0) state <= COLUMN; else cnt <= cnt - 1'b1;
        COLUMN: begin
          state <= WAIT_CL;
          cnt   <= CNT_W'(`DDR4_CAS_LATENCY - 2);
        end
        WAIT_CL: if (cnt == '0) state <= PRECHARGE; else cnt <= cnt - 1'b1;
        PRECHARGE: begin
          state <= WAIT_RP;
          cnt   <= CNT_W'(`DDR4_PRECHARGE_LATENCY - 2);
        end
        WAIT_RP: if (cnt == '0) state <= IDLE; else cnt <= cnt - 1'b1;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (state == IDLE && valid) req_q <= req;  // Accepted request
  end

  always_comb begin
    cmd      = '0;
    cmd.cs_n = 1'b1;
    cmd.act  = 1'b1;
    cmd.bg   = bank[3:2];
    cmd.ba   = bank[1:0];
    dq_wr    = '0;
    case (state)
      ACTIVATE: begin
        cmd.cs_n = 1'b0;
        cmd.act  = 1'b0;
        cmd.addr = 17'(row);
      end
      COLUMN: begin
        cmd.cs_n = 1'b0;
        cmd.addr[16:14] = is_write ? 3'b100 : 3'b101;  // WRITE or READ
        cmd.addr[`DDR4_COL_BITS-1:0] = col;
        if (is_write) begin
          cmd.dqm = req_q.wmask;
          dq_wr   = req_q.wdata;
        end
      end
      PRECHARGE: begin
        cmd.cs_n = 1'b0;
        cmd.addr[16:14] = 3'b010;
      end
      default: ;
    endcase
  end

endmodule

/* hw/ddr4_cmd_decode.sv */
`timescale 1ns/100ps
`include "ddr4_cfg.svh"

module ddr4_cmd_decode import ddr4_pkg::*; (
  input  logic      clk_in,
  input  logic      rst_n,
  input  dram_cmd_t cmd,
  input  data_t     dq_wr,
  output bank_ctl_t bank_ctl [`DDR4_NUM_BANKS]
);

  dram_op_e                  op;
  bank_idx_t                 bank;
  logic [`DDR4_NUM_BANKS-1:0] act_q, rd_q, wr_q, pre_q;
  row_t                      row_q;
  col_t                      col_q;
  data_t                     wdata_q;
  mask_t                     dqm_q;

  assign bank = {cmd.bg, cmd.ba};

  always_comb begin
    op = OP_NOP;
    if (!cmd.cs_n) begin
      if (!cmd.act) begin
        op = OP_ACTIVATE;
      end else begin
        case (cmd.addr[16:14])  // RAS_n, CAS_n, WE_n
          3'b101:  op = OP_READ;
          3'b100:  op = OP_WRITE;
          3'b010:  op = OP_PRECHARGE;
          default: op = OP_NOP;
        endcase
      end
    end
  end

  // One-hot bank select
  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      act_q <= '0;
      rd_q  <= '0;
      wr_q  <= '0;
      pre_q <= '0;
    end else begin
      for (int i = 0; i < `DDR4_NUM_BANKS; i++) begin
        act_q[i] <= (op == OP_ACTIVATE) && (bank == bank_idx_t'(i));
        rd_q[i]  <= (op == OP_READ) && (bank == bank_idx_t'(i));
        wr_q[i]  <= (op == OP_WRITE) && (bank == bank_idx_t'(i));
        pre_q[i] <= (op == OP_PRECHARGE) && (bank == bank_idx_t'(i));
      end
    end
  end

  // Payload shared by all banks
  always_ff @(posedge clk_in) begin
    row_q   <= cmd.addr[`DDR4_ROW_BITS-1:0];
    col_q   <= cmd.addr[`DDR4_COL_BITS-1:0];
    wdata_q <= dq_wr;
    dqm_q   <= cmd.dqm;
  end

  always_comb begin
    for (int i = 0; i < `DDR4_NUM_BANKS; i++) begin
      bank_ctl[i] = '{act: act_q[i], rd: rd_q[i], wr: wr_q[i], pre: pre_q[i],
                      row: row_q, col: col_q, wdata: wdata_q, dqm: dqm_q};
    end
  end

endmodule

/* hw/ddr4_bank.sv */
`timescale 1ns/100ps
`include "ddr4_cfg.svh"

module ddr4_bank import ddr4_pkg::*; (
  input  logic      clk_in,
  input  logic      rst_n,
  input  bank_ctl_t ctl,
  output data_t     rd_data
);

  localparam int AW = `DDR4_ROW_BITS + `DDR4_COL_BITS;

  data_t         mem [2**AW];
  row_t          open_row;
  logic          row_open;
  logic [AW-1:0] word_addr;

  assign word_addr = {open_row, ctl.col};

  initial begin
    for (int i = 0; i < 2**AW; i++) mem[i] = '0;  // Cells power up cleared
  end

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      open_row <= '0;
      row_open <= 1'b0;
    end else if (ctl.act) begin
      open_row <= ctl.row;
      row_open <= 1'b1;
    end else if (ctl.pre) begin
      row_open <= 1'b0;
    end
  end

  always_ff @(posedge clk_in) begin
    if (ctl.wr && row_open)
      mem[word_addr] <= (mem[word_addr] & ctl.dqm) | (ctl.wdata & ~ctl.dqm);
    if (ctl.rd) rd_data <= mem[word_addr];  // Held until next read
  end

endmodule

/* hw/ddr4_read_mux.sv */
`timescale 1ns/100ps
`include "ddr4_cfg.svh"

module ddr4_read_mux import ddr4_pkg::*; (
  input  logic       clk_in,
  input  logic       rst_n,
  input  rd_strobe_t rd_strobe,
  input  data_t      bank_data [`DDR4_NUM_BANKS],
  output data_t      read_data,
  output logic       rd_valid
);

  // Decoder and strobe register take two of the CL cycles
  localparam int DATA_STAGES = `DDR4_CAS_LATENCY - 2;

  rd_strobe_t             strobe_q;
  logic [DATA_STAGES-1:0] valid_pipe;
  data_t                  data_pipe [DATA_STAGES];

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      strobe_q   <= '0;
      valid_pipe <= '0;
    end else begin
      strobe_q   <= rd_strobe;
      valid_pipe <= {valid_pipe[DATA_STAGES-2:0], strobe_q.valid};
    end
  end

  // Word taken as soon as the bank has it
  always_ff @(posedge clk_in) begin
    data_pipe[0] <= bank_data[strobe_q.bank];
    for (int i = 1; i < DATA_STAGES; i++) data_pipe[i] <= data_pipe[i-1];
  end

  assign read_data = data_pipe[DATA_STAGES-1];
  assign rd_valid = valid_pipe[DATA_STAGES-1];

endmodule

/* hw/ddr4_dimm.sv */
`timescale 1ns/100ps
`include "ddr4_cfg.svh"

module ddr4_dimm import ddr4_pkg::*; (
  input  logic      clk_in,
  input  logic      rst_n,
  input  dram_cmd_t cmd,
  input  data_t     dq_wr,
  output data_t     read_data,
  output logic      rd_valid
);

  bank_ctl_t  bank_ctl [`DDR4_NUM_BANKS];
  data_t      bank_data [`DDR4_NUM_BANKS];
  rd_strobe_t rd_strobe;

  ddr4_cmd_decode u_cmd_decode (
    .clk_in   (clk_in),
    .rst_n    (rst_n),
    .cmd      (cmd),
    .dq_wr    (dq_wr),
    .bank_ctl (bank_ctl)
  );

  for (genvar b = 0; b < `DDR4_NUM_BANKS; b++) begin : g_bank
    ddr4_bank u_bank (
      .clk_in  (clk_in),
      .rst_n   (rst_n),
      .ctl     (bank_ctl[b]),
      .rd_data (bank_data[b])
    );
  end

  // At most one read strobe is set per cycle
  always_comb begin
    rd_strobe = '0;
    for (int i = 0; i < `DDR4_NUM_BANKS; i++) begin
      if (bank_ctl[i].rd) begin
        rd_strobe.valid = 1'b1;
        rd_strobe.bank  = bank_idx_t'(i);
      end
    end
  end

  ddr4_read_mux u_read_mux (
    .clk_in    (clk_in),
    .rst_n     (rst_n),
    .rd_strobe (rd_strobe),
    .bank_data (bank_data),
    .read_data (read_data),
    .rd_valid  (rd_valid)
  );

endmodule

/* hw/ddr4_system.sv */
`timescale 1ns/100ps

module ddr4_system import ddr4_pkg::*; (
  input  logic      clk_in,
  input  logic      rst_n,
  input  logic      valid,
  input  mem_req_t  req,
  output logic      busy,
  output data_t     read_data,
  output logic      read_valid,
  output dram_cmd_t cmd
);

  data_t dq_wr;  // Write data, separate from the read path

  ddr4_sdram_controller u_controller (
    .clk_in (clk_in),
    .rst_n  (rst_n),
    .valid  (valid),
    .req    (req),
    .busy   (busy),
    .cmd    (cmd),
    .dq_wr  (dq_wr)
  );

  ddr4_dimm u_dimm (
    .clk_in    (clk_in),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .dq_wr     (dq_wr),
    .read_data (read_data),
    .rd_valid  (read_valid)
  );

endmodule

/* test/ddr4_checker.sv */
`timescale 1ns/100ps
`include "ddr4_cfg.svh"

module ddr4_checker import ddr4_pkg::*; (
  input  logic            clk_in,
  input  logic            rst_n,
  input  logic            valid,
  input  mem_req_t        req,
  input  logic            busy,
  input  data_t           read_data,
  input  logic            read_valid,
  input  dram_cmd_t       cmd,
  input  logic [8*24-1:0] test_name,
  output int              error_count,
  output int              read_count
);

  // Command slots and read return counted from acceptance
  localparam int COL_DELAY = 1 + `DDR4_ACTIVATION_LATENCY;
  localparam int READ_DELAY = COL_DELAY + `DDR4_CAS_LATENCY;
  localparam int BUSY_CYCLES = READ_DELAY + `DDR4_PRECHARGE_LATENCY;
  localparam int IDX_W = $bits(bank_idx_t) + `DDR4_ROW_BITS + `DDR4_COL_BITS;

  typedef struct packed {
    logic [8*24-1:0] name;
    data_t           data;
    int              cycle;
  } read_expect_t;

  data_t            ref_mem [logic [IDX_W-1:0]];  // Unwritten words read as zero
  read_expect_t     pending [$];
  read_expect_t     exp_rd;
  logic [IDX_W-1:0] key;
  int               cycle;
  int               accept_cycle;
  logic             accept_write;
  logic             reset_checked;
  logic             exp_busy;
  logic [4:0]       exp_pins;  // {cs_n, act, RAS_n, CAS_n, WE_n}
  logic [4:0]       got_pins;

  function automatic data_t merge_word(data_t stored, data_t wdata, mask_t wmask);
    data_t merged;
    for (int i = 0; i < $bits(data_t); i++) begin
      merged[i] = wmask[i] ? stored[i] : wdata[i];  // Set mask bit keeps old bit
    end
    return merged;
  endfunction

  function automatic data_t stored_word(logic [IDX_W-1:0] k);
    return ref_mem.exists(k) ? ref_mem[k] : '0;
  endfunction

  task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
    $display("FAILED %s: expected %h actual %h", name, expected, actual);
    error_count++;
  endtask

  always @(posedge clk_in) begin
    cycle++;
    if (!rst_n) begin
      error_count   = 0;
      read_count    = 0;
      accept_cycle  = -100;
      accept_write  = 1'b0;
      reset_checked = 1'b0;
      pending.delete();
    end else begin
      // First cycle out of reset checks cs_n, act, busy and read_valid
      if (!reset_checked) begin
        reset_checked = 1'b1;
        if ({cmd.cs_n, cmd.act, busy, read_valid} !== 4'b1100)
          report_mismatch("reset_state", 64'(4'b1100),
                          64'({cmd.cs_n, cmd.act, busy, read_valid}));
      end
      exp_busy = (cycle > accept_cycle) && (cycle < accept_cycle + BUSY_CYCLES);
      if (busy !== exp_busy)
        report_mismatch($sformatf("%0s busy", test_name), 64'(exp_busy), 64'(busy));
      exp_pins = 5'b1_0000;  // Idle pins need only cs_n high
      if (cycle == accept_cycle + 1)
        exp_pins = 5'b0_0000;  // ACTIVATE with the row in the low addr bits
      else if (cycle == accept_cycle + COL_DELAY)
        exp_pins = accept_write ? 5'b0_1100 : 5'b0_1101;
      else if (cycle == accept_cycle + READ_DELAY)
        exp_pins = 5'b0_1010;
      got_pins = {cmd.cs_n, cmd.act, cmd.addr[16:14]};
      if (exp_pins[4] ? (cmd.cs_n !== 1'b1) : (got_pins !== exp_pins))
        report_mismatch($sformatf("%0s command", test_name), 64'(exp_pins),
                        64'(got_pins));
      if (read_valid) begin
        if (pending.size() == 0) begin
          $display("ERROR: read_valid pulsed with no read outstanding");
          error_count++;
        end else begin
          exp_rd = pending.pop_front();
          read_count++;
          if (cycle != exp_rd.cycle)
            report_mismatch($sformatf("%0s latency", exp_rd.name), 64'(exp_rd.cycle),
                            64'(cycle));
          if (read_data !== exp_rd.data)
            report_mismatch($sformatf("%0s", exp_rd.name), exp_rd.data, read_data);
        end
      end
      if (valid && !busy) begin
        accept_cycle = cycle;
        accept_write = req.addr[`DDR4_PADDR_BITS-1];
        key = req.addr[IDX_W-1:0];  // Bits 17:16 ignored
        if (accept_write) begin
          ref_mem[key] = merge_word(stored_word(key), req.wdata, req.wmask);
        end else begin
          pending.push_back('{name: test_name, data: stored_word(key),
                              cycle: cycle + READ_DELAY});
        end
      end
    end
  end

endmodule

/* test/ddr4_system_tb.sv */
`timescale 1ns/100ps
`include "ddr4_cfg.svh"

module ddr4_system_tb import ddr4_pkg::*; ();

  localparam int IDLE_TIMEOUT = 100;
  localparam int READ_TIMEOUT = 60;

  logic            clk_in = 1'b0;
  logic            rst_n = 1'b0;
  logic            valid = 1'b0;
  mem_req_t        req = '0;
  logic            busy;
  data_t           read_data;
  logic            read_valid;
  dram_cmd_t       cmd;
  logic [8*24-1:0] test_name = "reset_state";
  int              error_count;
  int              read_count;
  int              reads_issued = 0;
  paddr_t          addr;

  always #2 clk_in = ~clk_in;  // 4 ns period

  ddr4_system u_ddr4_system (
    .clk_in     (clk_in),
    .rst_n      (rst_n),
    .valid      (valid),
    .req        (req),
    .busy       (busy),
    .read_data  (read_data),
    .read_valid (read_valid),
    .cmd        (cmd)
  );

  ddr4_checker u_checker (
    .clk_in      (clk_in),
    .rst_n       (rst_n),
    .valid       (valid),
    .req         (req),
    .busy        (busy),
    .read_data   (read_data),
    .read_valid  (read_valid),
    .cmd         (cmd),
    .test_name   (test_name),
    .error_count (error_count),
    .read_count  (read_count)
  );

  function automatic paddr_t make_addr(bank_idx_t bank, row_t row, col_t col);
    return {1'b0, 2'b00, bank, row, col};
  endfunction

  task automatic abort_run(string what);
    $display("ERROR: timed out waiting for %s", what);
    $display("Test failed");
    $finish;
  endtask

  task automatic apply_reset();
    repeat (4) @(posedge clk_in);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk_in);
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    @(posedge clk_in);
    while (busy) begin
      if (n == IDLE_TIMEOUT) abort_run("busy to fall");
      n++;
      @(posedge clk_in);
    end
  endtask

  // Request accepted on the edge after valid is driven
  task automatic send(paddr_t a, data_t d, mask_t m);
    wait_idle();
    valid <= 1'b1;
    req   <= '{addr: a, wdata: d, wmask: m};
    @(posedge clk_in);
    valid <= 1'b0;
  endtask

  task automatic write_word(paddr_t a, data_t d, mask_t m);
    send({1'b1, a[`DDR4_PADDR_BITS-2:0]}, d, m);
  endtask

  task automatic read_word(paddr_t a);
    int n;
    n = 0;
    send({1'b0, a[`DDR4_PADDR_BITS-2:0]}, {$urandom, $urandom}, {$urandom, $urandom});
    reads_issued++;
    @(posedge clk_in);
    while (!read_valid) begin
      if (n == READ_TIMEOUT) abort_run("read_valid");
      n++;
      @(posedge clk_in);
    end
  endtask

  // Valid held high during busy; none of these may be taken
  task automatic drive_while_busy(paddr_t a, data_t d);
    valid <= 1'b1;
    req   <= '{addr: {1'b1, a[`DDR4_PADDR_BITS-2:0]}, wdata: d, wmask: '0};
    repeat (10) @(posedge clk_in);
    valid <= 1'b0;
  endtask

  initial begin
    void'($urandom(86));
    apply_reset();

    test_name = "write_read";
    write_word(make_addr(4'h5, 8'h21, 4'h3), 64'h0123_4567_89ab_cdef, '0);
    read_word(make_addr(4'h5, 8'h21, 4'h3));

    test_name = "masked_write";
    write_word(make_addr(4'h5, 8'h21, 4'h3), 64'hfedc_ba98_7654_3210,
               64'hffff_0000_ff00_00f0);
    read_word(make_addr(4'h5, 8'h21, 4'h3));

    test_name = "bank_independence";  // Same row and column in every bank
    for (int b = 0; b < `DDR4_NUM_BANKS; b++)
      write_word(make_addr(bank_idx_t'(b), 8'h40, 4'h7), {16'(b), 48'hab_cdef_1234}, '0);
    for (int b = 0; b < `DDR4_NUM_BANKS; b++)
      read_word(make_addr(bank_idx_t'(b), 8'h40, 4'h7));

    test_name = "dropped_request";
    write_word(make_addr(4'ha, 8'h12, 4'h0), 64'h1111_2222_3333_4444, '0);
    drive_while_busy(make_addr(4'ha, 8'h12, 4'h0), 64'hdead_beef_dead_beef);
    read_word(make_addr(4'ha, 8'h12, 4'h0));

    test_name = "random_ops";  // Small row and column range so reads hit writes
    repeat (200) begin
      addr = {1'b0, 2'($urandom), 4'($urandom), 8'($urandom_range(0, 3)),
              4'($urandom_range(0, 3))};
      if ($urandom_range(0, 1) == 1)
        write_word(addr, {$urandom, $urandom}, {$urandom, $urandom});
      else
        read_word(addr);
    end

    wait_idle();
    if (read_count != reads_issued)
      $display("ERROR: %0d reads issued but %0d returned", reads_issued, read_count);
    $display("Errors: %0d, reads checked: %0d of %0d", error_count, read_count, reads_issued);
    if (error_count == 0 && read_count == reads_issued) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* ddr4_system.f */
+incdir+include
hw/ddr4_pkg.sv
hw/ddr4_sdram_controller.sv
hw/ddr4_cmd_decode.sv
hw/ddr4_bank.sv
hw/ddr4_read_mux.sv
hw/ddr4_dimm.sv
hw/ddr4_system.sv
test/ddr4_checker.sv
test/ddr4_system_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the DDR4 subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f ddr4_system.f --top-module ddr4_system_tb \
  -o ddr4_system_sim

./obj_dir/ddr4_system_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test completed successfully$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation did not pass, see sim.log"
  exit 1
fi
